// File: run.sh
#!/bin/sh
# Builds the instruction translation buffer testbench with Verilator and runs it.
# The exit status is zero only when the run prints the pass message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module itlb_tb &&
./obj_dir/Vitlb_tb | tee /dev/stderr | grep -q "Regression passed" &&
echo "simulation finished cleanly" ||
{ echo "simulation did not finish cleanly"; exit 1; }

// File: sim.f
src/itlb_pkg.sv
src/itlb_space.sv
src/itlb_way.sv
src/itlb_array.sv
src/itlb_resp.sv
src/itlb_top.sv
tb/itlb_tb.sv

// File: src/itlb_array.sv
// Instruction translation buffer, set array stage
// Clears every set after reset, then looks up the fetch address in all
// eight ways at once, selects the hitting way and spreads its rank so each
// way can update its own place in the replacement order.

`timescale 1ns/10ps

module itlb_array (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          read_en,
  input  logic [itlb_pkg::VA_W-1:0]     read_va,
  input  logic [itlb_pkg::SPACE_W-1:0]  space_id,
  input  logic                          write_en,
  input  logic [itlb_pkg::VA_W-1:0]     write_va,
  input  logic [itlb_pkg::DATA_W-1:0]   write_data,
  input  logic                          fstall,
  output logic                          ready,
  output logic                          lookup_hit,
  output logic [itlb_pkg::DATA_W-1:0]   lookup_data
);

  import itlb_pkg::*;

  logic               sweep_q;
  logic [SET_W-1:0]   sweep_cnt;
  logic               rank_upd;
  logic               fill;
  logic [WAYS-1:0]    way_hit;
  logic [DATA_W-1:0]  way_data [WAYS];
  logic [RANK_W-1:0]  way_rank [WAYS];
  logic [WAYS-1:0]    way_last;
  logic [RANK_W-1:0]  sel_rank;
  logic [RANK_W-1:0]  hit_rank;
  logic               hit_any;

  // one set per cycle, ready rises after the last one
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sweep_q   <= 1'b1;
      sweep_cnt <= '0;
    end
    else if (sweep_q)
    begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_cnt == SET_W'(SETS - 1))
        sweep_q <= 1'b0;
    end
  end

  assign ready = !sweep_q;

  // a fill wins over a read in the same cycle
  assign rank_upd = ready && read_en && !fstall && !write_en;
  assign fill     = ready && write_en;

  for (genvar k = 0; k < WAYS; k++)
  begin : g_way
    itlb_way #(.WAY_NO(k)) u_way (
      .clk       (clk),
      .rst       (rst),
      .sweep     (sweep_q),
      .sweep_set (sweep_cnt),
      .lookup_va (read_va),
      .space_id  (space_id),
      .rank_upd  (rank_upd),
      .fill      (fill),
      .fill_va   (write_va),
      .fill_data (write_data),
      .hit_rank  (hit_rank),
      .hit_any   (hit_any),
      .hit       (way_hit[k]),
      .data      (way_data[k]),
      .rank      (way_rank[k])
    );

    assign way_last[k] = (way_rank[k] == RANK_W'(WAYS - 1));
  end

  // at most one way hits, so the select is a plain or of masked words
  always_comb
  begin
    lookup_data = '0;
    sel_rank    = '0;
    for (int i = 0; i < WAYS; i++)
    begin
      if (way_hit[i])
      begin
        lookup_data = lookup_data | way_data[i];
        sel_rank    = sel_rank | way_rank[i];
      end
    end
  end

  assign lookup_hit = |way_hit;

  // a fill behaves like a hit on the last-ranked way
  assign hit_rank = fill ? RANK_W'(WAYS - 1) : sel_rank;
  assign hit_any  = fill || lookup_hit;

  one_way_hits: assert property (
    @(posedge clk) disable iff (rst)
    (ready && !write_en) |-> $onehot0(way_hit)
  );

  one_victim: assert property (
    @(posedge clk) disable iff (rst)
    fill |-> $onehot(way_last)
  );

endmodule

// File: src/itlb_pkg.sv
// Instruction translation buffer shared definitions
// Address split, entry field widths, control-register map and the
// control-register data word with its two decodings.

package itlb_pkg;

  // virtual address split into tag, set index and page offset
  localparam int VA_W     = 44;
  localparam int PAGE_OFF = 12;
  localparam int SET_W    = 8;
  localparam int SETS     = 256;
  localparam int TAG_W    = 24;

  // associativity and per-way rank order
  localparam int WAYS   = 8;
  localparam int RANK_W = 3;

  localparam int SPACE_W = 24;
  localparam int PPN_W   = 32;

  // translation word is {ppn, global, execute, user, spare}
  localparam int DATA_W      = 36;
  localparam int DATA_GLOBAL = 3;

  // control-register snoop bus
  localparam int CSR_ADDR_W = 16;
  localparam int CSR_DATA_W = 64;

  localparam logic [CSR_ADDR_W-1:0] CSR_SPACE = 16'h0021;
  localparam logic [CSR_ADDR_W-1:0] CSR_FLAGS = 16'h0030;

  // translation enable inside each 32-bit thread half of the flag word
  localparam int FLAG_VM = 5;

  // top address nibble of the window that bypasses translation
  localparam logic [3:0] UNCACHED_NIB = 4'hE;

  // one control-register data word, decoded according to the register written.
  // The space register carries a padded identifier per thread, the flag
  // register carries a full 32-bit flag half per thread
  typedef union packed {
    struct packed {
      logic [CSR_DATA_W/2-SPACE_W-1:0] pad1;
      logic [SPACE_W-1:0]              id1;
      logic [CSR_DATA_W/2-SPACE_W-1:0] pad0;
      logic [SPACE_W-1:0]              id0;
    } ids;
    logic [1:0][CSR_DATA_W/2-1:0] flags;
  } itlb_csr_word_u;

endpackage

// File: src/itlb_resp.sv
// Instruction translation buffer, response stage
// Registers the lookup result one cycle after an accepted read, answers
// the uncached window with an identity mapping, and freezes under stall.

`timescale 1ns/10ps

module itlb_resp (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         read_en,
  input  logic [itlb_pkg::VA_W-1:0]    read_va,
  input  logic                         write_en,
  input  logic                         ready,
  input  logic                         fstall,
  input  logic                         lookup_hit,
  input  logic [itlb_pkg::DATA_W-1:0]  lookup_data,
  output logic                         resp_valid,
  output logic                         resp_hit,
  output logic [itlb_pkg::DATA_W-1:0]  resp_data
);

  import itlb_pkg::*;

  logic              accept;
  logic              uncached;
  logic [DATA_W-1:0] ident;

  assign accept   = read_en && !write_en && ready && !fstall;
  assign uncached = (read_va[VA_W-1 -: 4] == UNCACHED_NIB);

  // page number is the upper address itself, every flag clear
  assign ident = {read_va[PAGE_OFF +: PPN_W], {(DATA_W - PPN_W){1'b0}}};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      resp_valid <= 1'b0;
      resp_hit   <= 1'b0;
    end
    else if (!fstall)
    begin
      resp_valid <= accept;
      if (accept)
        resp_hit <= uncached || lookup_hit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      resp_data <= uncached ? ident : lookup_data;
  end

  no_resp_in_sweep: assert property (
    @(posedge clk) disable iff (rst)
    $rose(resp_valid) |-> ready
  );

endmodule

// File: src/itlb_space.sv
// Instruction translation buffer, address-space stage
// Watches control-register writes for the per-thread space identifiers
// and the translation-enable flags, and presents the identifier of the
// thread currently fetching.

`timescale 1ns/10ps

module itlb_space (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             csr_en,
  input  logic [itlb_pkg::CSR_ADDR_W-1:0]  csr_addr,
  input  itlb_pkg::itlb_csr_word_u         csr_data,
  input  logic                             read_thread,
  output logic [itlb_pkg::SPACE_W-1:0]     space_id
);

  import itlb_pkg::*;

  logic [1:0][SPACE_W-1:0] thr_space;
  logic [1:0]              thr_vm;
  logic                    hit_space;
  logic                    hit_flags;

  assign hit_space = csr_en && (csr_addr == CSR_SPACE);
  assign hit_flags = csr_en && (csr_addr == CSR_FLAGS);

  // both threads are written together, one half of the word each
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      thr_space <= '0;
      thr_vm    <= '0;
    end
    else
    begin
      if (hit_space)
      begin
        thr_space[0] <= csr_data.ids.id0;
        thr_space[1] <= csr_data.ids.id1;
      end
      if (hit_flags)
      begin
        // only the translation enable matters to the fetch side
        thr_vm[0] <= csr_data.flags[0][FLAG_VM];
        thr_vm[1] <= csr_data.flags[1][FLAG_VM];
      end
    end
  end

  // with translation off the thread runs in space zero
  always_comb
  begin
    if (thr_vm[read_thread])
    begin
      space_id = thr_space[read_thread];
    end
    else
    begin
      space_id = '0;
    end
  end

  // a strobe with an undefined address could update either register
  csr_addr_known: assert property (
    @(posedge clk) disable iff (rst)
    csr_en |-> !$isunknown(csr_addr)
  );

endmodule

// File: src/itlb_top.sv
// Instruction translation buffer top level
// Space identifier stage, set array and response stage in a chain,
// giving a translation one cycle after the fetch request.

`timescale 1ns/10ps

module itlb_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          read_en,
  input  logic                          read_thread,
  input  logic [itlb_pkg::VA_W-1:0]     read_va,
  input  logic                          write_en,
  input  logic [itlb_pkg::VA_W-1:0]     write_va,
  input  logic [itlb_pkg::DATA_W-1:0]   write_data,
  input  logic                          csr_en,
  input  logic [itlb_pkg::CSR_ADDR_W-1:0] csr_addr,
  input  itlb_pkg::itlb_csr_word_u      csr_data,
  input  logic                          fstall,
  output logic                          ready,
  output logic                          resp_valid,
  output logic                          resp_hit,
  output logic [itlb_pkg::DATA_W-1:0]   resp_data
);

  import itlb_pkg::*;

  logic [SPACE_W-1:0] space_id;
  logic               lookup_hit;
  logic [DATA_W-1:0]  lookup_data;

  itlb_space u_space (
    .clk         (clk),
    .rst         (rst),
    .csr_en      (csr_en),
    .csr_addr    (csr_addr),
    .csr_data    (csr_data),
    .read_thread (read_thread),
    .space_id    (space_id)
  );

  itlb_array u_array (
    .clk         (clk),
    .rst         (rst),
    .read_en     (read_en),
    .read_va     (read_va),
    .space_id    (space_id),
    .write_en    (write_en),
    .write_va    (write_va),
    .write_data  (write_data),
    .fstall      (fstall),
    .ready       (ready),
    .lookup_hit  (lookup_hit),
    .lookup_data (lookup_data)
  );

  itlb_resp u_resp (
    .clk         (clk),
    .rst         (rst),
    .read_en     (read_en),
    .read_va     (read_va),
    .write_en    (write_en),
    .ready       (ready),
    .fstall      (fstall),
    .lookup_hit  (lookup_hit),
    .lookup_data (lookup_data),
    .resp_valid  (resp_valid),
    .resp_hit    (resp_hit),
    .resp_data   (resp_data)
  );

endmodule

// File: src/itlb_way.sv
// Instruction translation buffer, one way of the set array
// Holds valid, tag, space, translation word and rank for every set,
// compares the looked-up address combinationally and rewrites the
// selected set on a sweep, a fill or a rank update.

`timescale 1ns/10ps

module itlb_way #(
  parameter int WAY_NO = 0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          sweep,
  input  logic [itlb_pkg::SET_W-1:0]    sweep_set,
  input  logic [itlb_pkg::VA_W-1:0]     lookup_va,
  input  logic [itlb_pkg::SPACE_W-1:0]  space_id,
  input  logic                          rank_upd,
  input  logic                          fill,
  input  logic [itlb_pkg::VA_W-1:0]     fill_va,
  input  logic [itlb_pkg::DATA_W-1:0]   fill_data,
  input  logic [itlb_pkg::RANK_W-1:0]   hit_rank,
  input  logic                          hit_any,
  output logic                          hit,
  output logic [itlb_pkg::DATA_W-1:0]   data,
  output logic [itlb_pkg::RANK_W-1:0]   rank
);

  import itlb_pkg::*;

  logic               valid_q [SETS];
  logic [TAG_W-1:0]   tag_q   [SETS];
  logic [SPACE_W-1:0] space_q [SETS];
  logic [DATA_W-1:0]  data_q  [SETS];
  logic [RANK_W-1:0]  rank_q  [SETS];

  logic [SET_W-1:0]   set_idx;
  logic               cur_valid;
  logic [TAG_W-1:0]   cur_tag;
  logic [SPACE_W-1:0] cur_space;
  logic               victim;
  logic               we;
  logic [RANK_W-1:0]  upd_rank;
  logic               nxt_valid;
  logic [TAG_W-1:0]   nxt_tag;
  logic [SPACE_W-1:0] nxt_space;
  logic [DATA_W-1:0]  nxt_data;
  logic [RANK_W-1:0]  nxt_rank;

  // one port serves read and write, a fill takes the set of the fill address
  assign set_idx = sweep ? sweep_set :
                   fill  ? fill_va[PAGE_OFF +: SET_W] : lookup_va[PAGE_OFF +: SET_W];

  assign cur_valid = valid_q[set_idx];
  assign cur_tag   = tag_q[set_idx];
  assign cur_space = space_q[set_idx];
  assign data      = data_q[set_idx];
  assign rank      = rank_q[set_idx];

  // global pages ignore the space identifier
  assign hit = cur_valid && (cur_tag == lookup_va[VA_W-1 -: TAG_W]) &&
               ((cur_space == space_id) || data[DATA_GLOBAL]);

  assign victim = fill && (rank == RANK_W'(WAYS - 1));

  // the touched way moves to the front and the ways ahead of it slip back one
  always_comb
  begin
    if (!hit_any)
      upd_rank = rank;
    else if (rank == hit_rank)
      upd_rank = '0;
    else if (rank < hit_rank)
      upd_rank = rank + 1'b1;
    else
      upd_rank = rank;
  end

  always_comb
  begin
    nxt_valid = cur_valid;
    nxt_tag   = cur_tag;
    nxt_space = cur_space;
    nxt_data  = data;
    nxt_rank  = upd_rank;
    if (sweep)
    begin
      nxt_valid = 1'b0;
      nxt_rank  = RANK_W'(WAY_NO);
    end
    else if (victim)
    begin
      nxt_valid = 1'b1;
      nxt_tag   = fill_va[VA_W-1 -: TAG_W];
      nxt_space = space_id;
      nxt_data  = fill_data;
    end
  end

  assign we = !rst && (sweep || fill || (rank_upd && hit_any));

  always_ff @(posedge clk)
  begin
    if (we)
    begin
      valid_q[set_idx] <= nxt_valid;
      tag_q[set_idx]   <= nxt_tag;
      space_q[set_idx] <= nxt_space;
      data_q[set_idx]  <= nxt_data;
      rank_q[set_idx]  <= nxt_rank;
    end
  end

endmodule

// File: tb/itlb_tb.sv
// Testbench for the instruction translation buffer
// Drives fills, fetch reads, control-register writes and fetch stalls,
// keeps a reference model of the set array and checks every response
// with assertions.

`timescale 1ns/10ps

module itlb_tb;

  import itlb_pkg::*;

  localparam int N_RAND = 16;
  // cycles needed by the tests that follow the reset sweep
  localparam int TEST_CYCLES = 3 * N_RAND + 2 + 20 + 20 + 8 + 10 + 2;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  read_en;
  logic                  read_thread;
  logic [VA_W-1:0]       read_va;
  logic                  write_en;
  logic [VA_W-1:0]       write_va;
  logic [DATA_W-1:0]     write_data;
  logic                  csr_en;
  logic [CSR_ADDR_W-1:0] csr_addr;
  itlb_csr_word_u        csr_data;
  logic                  fstall;
  logic                  ready;
  logic                  resp_valid;
  logic                  resp_hit;
  logic [DATA_W-1:0]     resp_data;

  logic                  exp_hit;
  logic [DATA_W-1:0]     exp_data;
  logic                  swept;
  logic                  acc;
  int                    seed;
  int                    errors = 0;
  int                    checks = 0;

  // the reference model keeps all eight ways of one set under each key
  logic [WAYS-1:0]              m_valid [int];
  logic [WAYS-1:0][TAG_W-1:0]   m_tag   [int];
  logic [WAYS-1:0][SPACE_W-1:0] m_space [int];
  logic [WAYS-1:0][DATA_W-1:0]  m_data  [int];
  logic [WAYS-1:0][RANK_W-1:0]  m_rank  [int];
  logic [1:0][SPACE_W-1:0]      m_id;
  logic [1:0]                   m_vm;

  itlb_top UUT (.*);

  always #5 clk = ~clk;

  assign acc = read_en && !write_en && swept && !fstall;

  always @(posedge clk)
  begin
    if (!rst && acc)
      checks <= checks + 1;
  end

  task automatic report_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    errors++;
  endtask

  resp_matches: assert property (
    @(posedge clk) disable iff (rst)
    acc |=> resp_valid && (resp_hit == $past(exp_hit)) &&
            (!$past(exp_hit) || (resp_data == $past(exp_data)))
  )
  else report_error($sformatf("wrong response, valid %0b hit %0b data %h",
                              resp_valid, resp_hit, resp_data));

  // no accepted read and no stall leaves nothing to answer
  no_stray_resp: assert property (
    @(posedge clk) disable iff (rst)
    (!acc && !fstall) |=> !resp_valid
  )
  else report_error("response without an accepted read");

  stall_holds: assert property (
    @(posedge clk) disable iff (rst)
    (fstall && resp_valid) |=> $stable(resp_valid) && $stable(resp_hit) &&
                               $stable(resp_data)
  )
  else report_error("response changed under fetch stall");

  function automatic logic [VA_W-1:0] rand_va(input logic [3:0] nib,
                                              input logic [SET_W-1:0] set);
    logic [31:0] r;
    r = $random(seed);
    return {nib, r[31:12], set, r[11:0]};
  endfunction

  function automatic logic [DATA_W-1:0] rand_data(input logic glob);
    logic [31:0]       r;
    logic [DATA_W-1:0] d;
    r = $random(seed);
    d = {r, r[7:4] ^ r[31:28]};
    d[DATA_GLOBAL] = glob;
    return d;
  endfunction

  function automatic logic [SPACE_W-1:0] cur_space();
    return m_vm[read_thread] ? m_id[read_thread] : '0;
  endfunction

  // after the sweep every way is empty and way k sits at rank k
  task automatic model_clear();
    for (int s = 0; s < SETS; s++)
    begin
      m_valid[s] = '0;
      m_tag[s]   = '0;
      m_space[s] = '0;
      m_data[s]  = '0;
      for (int w = 0; w < WAYS; w++)
        m_rank[s][w] = RANK_W'(w);
    end
  endtask

  function automatic int model_lookup(input logic [VA_W-1:0] va);
    int s;
    s = int'(va[PAGE_OFF +: SET_W]);
    for (int w = 0; w < WAYS; w++)
      if (m_valid[s][w] && (m_tag[s][w] == va[VA_W-1 -: TAG_W]) &&
          ((m_space[s][w] == cur_space()) || m_data[s][w][DATA_GLOBAL]))
        return w;
    return -1;
  endfunction

  function automatic void model_touch(input int s, input int way);
    logic [RANK_W-1:0] r;
    r = m_rank[s][way];
    for (int w = 0; w < WAYS; w++)
    begin
      if (w == way)
        m_rank[s][w] = '0;
      else if (m_rank[s][w] < r)
        m_rank[s][w] = m_rank[s][w] + 1'b1;
    end
  endfunction

  task automatic do_fill(input logic [VA_W-1:0] va, input logic [DATA_W-1:0] d);
    int s;
    int v;
    s = int'(va[PAGE_OFF +: SET_W]);
    v = 0;
    // the least recently used way takes the new entry
    for (int w = 0; w < WAYS; w++)
      if (m_rank[s][w] == RANK_W'(WAYS - 1))
        v = w;
    m_valid[s][v] = 1'b1;
    m_tag[s][v]   = va[VA_W-1 -: TAG_W];
    m_space[s][v] = cur_space();
    m_data[s][v]  = d;
    model_touch(s, v);
    write_en   = 1'b1;
    write_va   = va;
    write_data = d;
    @(negedge clk);
    write_en = 1'b0;
  endtask

  task automatic do_read(input logic [VA_W-1:0] va);
    int s;
    int w;
    s = int'(va[PAGE_OFF +: SET_W]);
    w = model_lookup(va);
    exp_hit  = (w >= 0);
    exp_data = '0;
    if (w >= 0)
      exp_data = m_data[s][w];
    // the uncached window maps straight through with all flags clear
    if (va[VA_W-1 -: 4] == 4'hE)
    begin
      exp_hit  = 1'b1;
      exp_data = {va[VA_W-1:PAGE_OFF], 4'h0};
    end
    if ((w >= 0) && !fstall)
      model_touch(s, w);
    read_en = 1'b1;
    read_va = va;
    @(negedge clk);
    read_en = 1'b0;
  endtask

  task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input itlb_csr_word_u word);
    if (addr == CSR_SPACE)
      m_id = {word.ids.id1, word.ids.id0};
    else if (addr == CSR_FLAGS)
      m_vm = {word.flags[1][FLAG_VM], word.flags[0][FLAG_VM]};
    csr_en   = 1'b1;
    csr_addr = addr;
    csr_data = word;
    @(negedge clk);
    csr_en = 1'b0;
  endtask

  // two idle cycles let the last response reach its assertion first
  task automatic end_test(input string name, input int err_before);
    repeat (2) @(negedge clk);
    if (errors == err_before)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, errors - err_before);
  endtask

  initial
  begin
    logic [VA_W-1:0] vas [$];
    logic [VA_W-1:0] va;
    logic [VA_W-1:0] va_a;
    logic [VA_W-1:0] va_b;
    logic [VA_W-1:0] va_c;
    itlb_csr_word_u  w;
    int              n;
    int              e;
    seed        = 32'h3267;
    rst         = 1'b1;
    read_en     = 1'b0;
    read_thread = 1'b0;
    read_va     = '0;
    write_en    = 1'b0;
    write_va    = '0;
    write_data  = '0;
    csr_en      = 1'b0;
    csr_addr    = '0;
    csr_data    = '0;
    fstall      = 1'b0;
    exp_hit     = 1'b0;
    exp_data    = '0;
    swept       = 1'b0;
    m_id        = '0;
    m_vm        = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // reads offered during the sweep must go unanswered
    e = errors;
    n = 0;
    assert (!resp_valid) else report_error("resp_valid high after reset");
    while (!ready)
    begin
      n++;
      read_en = 1'b1;
      read_va = rand_va(4'h3, 8'(n));
      @(negedge clk);
    end
    read_en = 1'b0;
    swept   = 1'b1;
    assert (n == SETS)
    else report_error($sformatf("ready low for %0d cycles, expected %0d", n, SETS));
    model_clear();
    end_test("reset sweep", e);

    e = errors;
    for (int i = 0; i < N_RAND; i++)
    begin
      va = rand_va(4'h1, 8'(i * 13));
      vas.push_back(va);
      do_fill(va, rand_data(1'b0));
    end
    foreach (vas[i])
      do_read(vas[i]);
    for (int i = 0; i < N_RAND; i++)
      do_read(rand_va(4'h2, 8'(i * 7)));
    end_test("random fill and read back", e);

    // va_c lives in space 0, va_a is private to space A, va_b is global
    e = errors;
    va_a = rand_va(4'h1, 8'd201);
    va_b = rand_va(4'h1, 8'd202);
    va_c = rand_va(4'h1, 8'd200);
    do_fill(va_c, rand_data(1'b0));
    w = '0;
    w.ids.id0 = 24'hA0A0A1;
    w.ids.id1 = 24'h0B0B0B;
    csr_write(CSR_SPACE, w);
    w = '0;
    w.flags[0][FLAG_VM] = 1'b1;
    csr_write(CSR_FLAGS, w);
    do_fill(va_a, rand_data(1'b0));
    do_fill(va_b, rand_data(1'b1));
    do_read(va_a);
    do_read(va_b);
    do_read(va_c);
    w = '0;
    w.ids.id0 = 24'hB0B0B2;
    csr_write(CSR_SPACE, w);
    do_read(va_a);
    do_read(va_b);
    w = '0;
    csr_write(CSR_FLAGS, w);
    do_read(va_c);
    do_read(va_a);
    do_read(va_b);
    end_test("address space and global pages", e);

    e = errors;
    vas.delete();
    for (int i = 0; i < WAYS + 1; i++)
    begin
      va = rand_va(4'h4, 8'd220);
      va[23:20] = 4'(i);
      vas.push_back(va);
      do_fill(va, rand_data(1'b0));
    end
    foreach (vas[i])
      do_read(vas[i]);
    end_test("replacement order", e);

    e = errors;
    for (int i = 0; i < 6; i++)
      do_read(rand_va(4'hE, 8'($random(seed))));
    end_test("uncached window", e);

    // the read of va_b waits behind the stall and is answered after it
    e = errors;
    va_a = rand_va(4'h5, 8'd230);
    va_b = rand_va(4'h5, 8'd231);
    do_fill(va_a, rand_data(1'b0));
    do_fill(va_b, rand_data(1'b0));
    do_read(va_a);
    fstall  = 1'b1;
    read_en = 1'b1;
    read_va = va_b;
    repeat (3) @(negedge clk);
    fstall = 1'b0;
    do_read(va_b);
    end_test("fetch stall", e);

    $display("tests 6, responses checked %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin
    #((2 + SETS + TEST_CYCLES) * 2 * 10);
    $display("timeout: the tests did not complete within the expected time");
    $display("Regression failed");
    $finish;
  end

endmodule
